// File: verilog/l2_cache_macros.svh
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// cache geometry.
`define L2_NUM_SETS    16
`define L2_NUM_WAYS    4
`define L2_OFFSET_BITS 5
`define L2_INDEX_BITS  4
`define L2_TAG_BITS    7
`define L2_LINE_BITS   256

`endif

// File: verilog/lc3b_types.sv
`include "l2_cache_macros.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;

    // address split, tag | index | offset.
    typedef logic [`L2_TAG_BITS-1:0] lc3b_c_l2_tag;
    typedef logic [`L2_INDEX_BITS-1:0] lc3b_c_l2_index;

    // word offset, byte bit dropped.
    typedef logic [`L2_OFFSET_BITS-2:0] lc3b_c_l2_offset;

    typedef logic [`L2_LINE_BITS-1:0] lc3b_c_l2_line;

endpackage : lc3b_types

// File: verilog/l2_cache_types.sv
`include "l2_cache_macros.svh"

package l2_cache_types;

    typedef logic [$clog2(`L2_NUM_WAYS)-1:0] l2_way;

    // one bit per internal node of the tree.
    typedef logic [`L2_NUM_WAYS-2:0] l2_lru_tree;

    typedef enum logic [1:0] {
        idle_rw_cache,
        cache_hit,
        phys_mem_write,
        phys_mem_read
    } l2_ctrl_state;

endpackage : l2_cache_types

// File: verilog/l2_array_if.sv
`timescale 1ns/1ps

interface l2_array_if import lc3b_types::*, l2_cache_types::*;
();

    // lookup results.
    logic         hit;
    l2_way        hit_way;
    l2_way        lru_way;       // victim way.
    logic         victim_dirty;
    lc3b_c_l2_tag victim_tag;

    // controller commands.
    l2_way        access_way;
    logic         ld_line;
    logic         ld_dirty;
    logic         dirty_value;
    logic         ld_lru;
    logic         write_word;

    modport ctrl (
        input  hit, hit_way, lru_way, victim_dirty, victim_tag,
        output access_way, ld_line, ld_dirty, dirty_value, ld_lru, write_word
    );

    modport lookup (
        output hit, hit_way, lru_way, victim_dirty, victim_tag,
        input  access_way, ld_line, ld_dirty, dirty_value, ld_lru
    );

    modport store (input access_way, hit_way, lru_way, ld_line, write_word);

endinterface : l2_array_if

// File: verilog/l2_tag_lookup.sv
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_tag_lookup import lc3b_types::*, l2_cache_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  lc3b_word mem_address,
    l2_array_if.lookup arr
);

    lc3b_c_l2_tag   tags  [`L2_NUM_SETS][`L2_NUM_WAYS];
    logic [`L2_NUM_WAYS-1:0] valid [`L2_NUM_SETS];
    logic [`L2_NUM_WAYS-1:0] dirty [`L2_NUM_SETS];
    l2_lru_tree     lru   [`L2_NUM_SETS];

    lc3b_c_l2_tag   addr_tag;
    lc3b_c_l2_index index;
    l2_lru_tree     tree;

    assign addr_tag = mem_address[15 -: `L2_TAG_BITS];
    assign index    = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign tree     = lru[index];

    always_comb
    begin
        arr.hit     = 1'b0;
        arr.hit_way = '0;
        for (int w = 0; w < `L2_NUM_WAYS; w++)
        begin
            if (valid[index][w] && tags[index][w] == addr_tag)
            begin
                arr.hit     = 1'b1;
                arr.hit_way = l2_way'(w);
            end
        end
    end

    // root picks the pair, then the pair bit picks the way.
    assign arr.lru_way      = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    assign arr.victim_dirty = valid[index][arr.lru_way] & dirty[index][arr.lru_way];
    assign arr.victim_tag   = tags[index][arr.lru_way];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `L2_NUM_SETS; s++)
            begin
                valid[s] <= '0;
                lru[s]   <= '0;
            end
        end
        else
        begin
            if (arr.ld_line)
                valid[index][arr.access_way] <= 1'b1;
            if (arr.ld_lru)
            begin
                lru[index][0] <= ~arr.access_way[1]; // point away.
                if (arr.access_way[1])
                    lru[index][2] <= ~arr.access_way[0];
                else
                    lru[index][1] <= ~arr.access_way[0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (arr.ld_line)
        begin
            tags[index][arr.access_way]  <= addr_tag;
            dirty[index][arr.access_way] <= 1'b0;   // fresh fill is clean.
        end
        else if (arr.ld_dirty)
            dirty[index][arr.access_way] <= arr.dirty_value;
    end

endmodule : l2_tag_lookup

// File: verilog/l2_cache_control.sv
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_cache_control import lc3b_types::*, l2_cache_types::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_read,
    input  logic     mem_write,
    input  lc3b_word mem_address,
    input  logic     pmem_resp,
    output logic     mem_resp,
    output logic     pmem_read,
    output logic     pmem_write,
    output lc3b_word pmem_address,
    l2_array_if.ctrl arr
);

    l2_ctrl_state   state;
    l2_ctrl_state   next_state;
    lc3b_c_l2_index index;
    logic           request;

    assign index   = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign request = mem_read | mem_write;

    always_comb
    begin : state_actions
        arr.access_way  = arr.lru_way;
        arr.ld_line     = 1'b0;
        arr.ld_dirty    = 1'b0;
        arr.dirty_value = 1'b0;
        arr.ld_lru      = 1'b0;
        arr.write_word  = 1'b0;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        // line aligned request address.
        pmem_address    = {mem_address[15:`L2_OFFSET_BITS], {`L2_OFFSET_BITS{1'b0}}};

        case (state)
            idle_rw_cache: ;

            cache_hit:
            begin
                arr.access_way = arr.hit_way;
                if (arr.hit)
                begin
                    mem_resp   = 1'b1;
                    arr.ld_lru = 1'b1;
                    if (mem_write)
                    begin
                        arr.write_word  = 1'b1;
                        arr.ld_dirty    = 1'b1;
                        arr.dirty_value = 1'b1;
                    end
                end
            end

            phys_mem_write:
            begin
                // write back victim, then mark it clean.
                arr.ld_dirty    = 1'b1;
                arr.dirty_value = 1'b0;
                pmem_write      = 1'b1;
                pmem_address    = {arr.victim_tag, index, {`L2_OFFSET_BITS{1'b0}}};
            end

            phys_mem_read:
            begin
                pmem_read   = 1'b1;
                arr.ld_line = pmem_resp; // fill on the response cycle.
            end

            default: ;
        endcase
    end

    always_comb
    begin : next_state_logic
        next_state = state;
        case (state)
            idle_rw_cache:
            begin
                if (request && arr.hit)
                    next_state = cache_hit;
                else if (request)
                    next_state = arr.victim_dirty ? phys_mem_write : phys_mem_read;
            end

            cache_hit:
                next_state = idle_rw_cache;

            phys_mem_write:
            begin
                if (pmem_resp)
                    next_state = phys_mem_read;
            end

            phys_mem_read:
            begin
                if (pmem_resp)
                    next_state = idle_rw_cache; // request hits next pass.
            end

            default:
                next_state = idle_rw_cache;
        endcase
    end

    always_ff @(posedge clk)
    begin : next_state_assignment
        if (reset)
            state <= idle_rw_cache;
        else
            state <= next_state;
    end

endmodule : l2_cache_control

// File: verilog/l2_line_store.sv
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_line_store import lc3b_types::*;
(
    input  logic          clk,
    input  lc3b_word      mem_address,
    input  lc3b_word      mem_wdata,
    input  lc3b_c_l2_line pmem_rdata,
    output lc3b_word      mem_rdata,
    output lc3b_c_l2_line pmem_wdata,
    l2_array_if.store     arr
);

    // one line array per way.
    lc3b_c_l2_line data [`L2_NUM_WAYS][`L2_NUM_SETS];

    lc3b_c_l2_index  index;
    lc3b_c_l2_offset offset;
    logic [7:0]      word_sel;
    lc3b_c_l2_line   hit_line;
    lc3b_c_l2_line   merged_line;

    assign index    = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign offset   = mem_address[`L2_OFFSET_BITS-1:1];
    assign word_sel = {offset, 4'b0000}; // bit position of the word.

    assign hit_line = data[arr.hit_way][index];

    // replace one word of the line being accessed.
    always_comb
    begin
        merged_line = data[arr.access_way][index];
        merged_line[word_sel +: 16] = mem_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (arr.ld_line)
            data[arr.access_way][index] <= pmem_rdata;
        else if (arr.write_word)
            data[arr.access_way][index] <= merged_line;
    end

    assign mem_rdata  = hit_line[word_sel +: 16];
    assign pmem_wdata = data[arr.lru_way][index]; // victim line.

endmodule : l2_line_store

// File: verilog/l2_cache.sv
`timescale 1ns/1ps

module l2_cache import lc3b_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          mem_read,
    input  logic          mem_write,
    input  lc3b_word      mem_address,
    input  lc3b_word      mem_wdata,
    input  logic          pmem_resp,
    input  lc3b_c_l2_line pmem_rdata,
    output logic          mem_resp,
    output lc3b_word      mem_rdata,
    output logic          pmem_read,
    output logic          pmem_write,
    output lc3b_word      pmem_address,
    output lc3b_c_l2_line pmem_wdata
);

    l2_array_if arr ();

    l2_tag_lookup tag_lookup (
        .clk         (clk),
        .reset       (reset),
        .mem_address (mem_address),
        .arr         (arr.lookup)
    );

    l2_cache_control control (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .pmem_resp    (pmem_resp),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .arr          (arr.ctrl)
    );

    l2_line_store line_store (
        .clk         (clk),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .pmem_rdata  (pmem_rdata),
        .mem_rdata   (mem_rdata),
        .pmem_wdata  (pmem_wdata),
        .arr         (arr.store)
    );

endmodule : l2_cache

// File: testbench/l2_pmem_model.sv
`timescale 1ns/1ps

module l2_pmem_model import lc3b_types::*;
(
    input  logic          clk,
    input  logic          pmem_read,
    input  logic          pmem_write,
    input  lc3b_word      pmem_address,
    input  lc3b_c_l2_line pmem_wdata,
    output logic          pmem_resp,
    output lc3b_c_l2_line pmem_rdata
);

    lc3b_word      mem [32768];   // indexed by word, 64 KB.
    logic          resp_q = 1'b0;
    lc3b_c_l2_line rdata_q = '0;
    int            wait_cnt = 0;
    int            read_count = 0;
    int            write_count = 0;

    assign pmem_resp  = resp_q;
    assign pmem_rdata = rdata_q;

    initial
    begin
        lc3b_word a;
        for (int w = 0; w < 32768; w++)
        begin
            a      = lc3b_word'(w << 1);
            mem[w] = {a[7:0], a[15:8]}; // byte address, bytes swapped.
        end
    end

    always @(posedge clk)
    begin
        resp_q <= 1'b0;
        if ((pmem_read || pmem_write) && !resp_q)
        begin
            if (wait_cnt < 3)
                wait_cnt <= wait_cnt + 1;
            else
            begin
                wait_cnt <= 0;
                resp_q   <= 1'b1;
                for (int i = 0; i < 16; i++)
                begin
                    if (pmem_write)
                        mem[{pmem_address[15:5], i[3:0]}] = pmem_wdata[16*i +: 16];
                    else
                        rdata_q[16*i +: 16] <= mem[{pmem_address[15:5], i[3:0]}];
                end
                if (pmem_write)
                    write_count <= write_count + 1;
                else
                    read_count <= read_count + 1;
            end
        end
    end

endmodule : l2_pmem_model

// File: testbench/l2_cache_chk.sv
`timescale 1ns/1ps

module l2_cache_chk import l2_cache_types::*;
(
    input logic         clk,
    input logic         reset,
    input logic         mem_resp,
    input logic         pmem_read,
    input logic         pmem_write,
    input logic         pmem_resp,
    input l2_ctrl_state state
);

    pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_resp |=> !mem_resp)
        else $error("mem_resp high for more than one cycle");

    // write-back holds until its response, then fills.
    writeback_then_fill: assert property (@(posedge clk) disable iff (reset)
        (state == phys_mem_write) |=>
            (state == ($past(pmem_resp) ? phys_mem_read : phys_mem_write)))
        else $error("phys_mem_write not followed by phys_mem_read");

endmodule : l2_cache_chk

// File: testbench/tb_l2_cache.sv
`timescale 1ns/1ps

module tb_l2_cache import lc3b_types::*, l2_cache_types::*;
();

    localparam int total_requests = 1 + 1 + 2 + 5 + 10 + 200;
    localparam int timeout_cycles = total_requests * 20 + 10;

    logic          clk;
    logic          reset;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_word      mem_wdata;
    logic          mem_resp;
    lc3b_word      mem_rdata;
    logic          pmem_resp;
    logic          pmem_read;
    logic          pmem_write;
    lc3b_word      pmem_address;
    lc3b_c_l2_line pmem_rdata;
    lc3b_c_l2_line pmem_wdata;

    lc3b_word    shadow [32768];  // memory as the processor sees it.
    logic [31:0] lfsr = 32'd97018;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          reads_before;
    int          writes_before;

    l2_cache UUT (.*);
    l2_pmem_model pmem (.*);

    bind l2_cache_control l2_cache_chk chk (
        .clk        (clk),
        .reset      (reset),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .pmem_resp  (pmem_resp),
        .state      (state)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles)
        begin
            $display("timeout: the cache stopped answering after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic lc3b_word make_addr(input int tag, input int set, input int word);
        return {tag[6:0], set[3:0], word[3:0], 1'b0};
    endfunction

    // walk from the root to the pair, then to the way.
    function automatic l2_way tree_victim(input l2_lru_tree t);
        int pair;
        pair = int'(t[0]);
        return l2_way'(2 * pair + int'(t[1 + pair]));
    endfunction

    function automatic l2_lru_tree tree_touch(input l2_lru_tree t, input l2_way w);
        l2_lru_tree n;
        int         pair;
        n    = t;
        pair = int'(w[1]);
        n[0] = (pair == 0);           // root points to the other pair.
        n[1 + pair] = (w[0] == 1'b0);
        return n;
    endfunction

    task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic mark_traffic();
        reads_before  = pmem.read_count;
        writes_before = pmem.write_count;
    endtask

    task automatic check_traffic(input int exp_reads, input int exp_writes);
        check_count("pmem reads", pmem.read_count - reads_before, exp_reads);
        check_count("pmem writes", pmem.write_count - writes_before, exp_writes);
    endtask

    // holds the request until mem_resp and counts the rising edges.
    task automatic cache_access(input logic wr, input lc3b_word addr, input lc3b_word wdata,
                                output lc3b_word rdata, output int cycles);
        mem_read    = ~wr;
        mem_write   = wr;
        mem_address = addr;
        mem_wdata   = wdata;
        cycles      = 0;
        @(negedge clk);
        while (!mem_resp)
        begin
            @(negedge clk);
            cycles++;
        end
        rdata = mem_rdata;
        @(posedge clk);
        cycles++;
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic cpu_read(input lc3b_word addr, output int cycles);
        lc3b_word rdata;
        cache_access(1'b0, addr, '0, rdata, cycles);
        check_word($sformatf("read of %h", addr), rdata, shadow[addr[15:1]]);
    endtask

    task automatic cpu_write(input lc3b_word addr, input lc3b_word data);
        lc3b_word rdata;
        int       cycles;
        cache_access(1'b1, addr, data, rdata, cycles);
        shadow[addr[15:1]] = data;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errors)
            tests_failed++;
        $display("test %-18s %s", name, (errors == test_start_errors) ? "pass" : "FAIL");
        test_start_errors = errors;
    endtask

    task automatic cold_read_miss();
        int cyc;
        mark_traffic();
        cpu_read(make_addr(1, 0, 3), cyc);
        check_traffic(1, 0);
    endtask

    task automatic same_line_hit();
        int cyc;
        mark_traffic();
        cpu_read(make_addr(1, 0, 7), cyc);
        check_count("hit latency", cyc, 2);
        check_traffic(0, 0);
    endtask

    task automatic write_hit_read();
        int cyc;
        mark_traffic();
        cpu_write(make_addr(1, 0, 5), 16'hbeef);
        cpu_read(make_addr(1, 0, 5), cyc);
        check_traffic(0, 0);
    endtask

    task automatic dirty_eviction();
        lc3b_word a;
        int       cyc;
        a = make_addr(10, 1, 9);
        mark_traffic();
        cpu_write(a, 16'h5a3c);     // the fifth tag evicts this line.
        for (int t = 11; t <= 14; t++)
            cpu_read(make_addr(t, 1, 0), cyc);
        check_traffic(5, 1);
        check_word("written back word", pmem.mem[a[15:1]], 16'h5a3c);
    endtask

    task automatic plru_order();
        int         seq [6] = '{20, 21, 22, 23, 20, 24};
        int         way_tag [4] = '{-1, -1, -1, -1};
        l2_lru_tree tree = '0;
        l2_way      w;
        int         victim = -1;
        int         cyc;
        for (int i = 0; i < 6; i++)
        begin
            w = tree_victim(tree);
            for (int k = 0; k < 4; k++)
            begin
                if (way_tag[k] == seq[i])
                    w = l2_way'(k);
            end
            victim     = way_tag[w];
            way_tag[w] = seq[i];
            tree       = tree_touch(tree, w);
            cpu_read(make_addr(seq[i], 2, i), cyc);
        end
        for (int k = 0; k < 4; k++)
        begin
            if (seq[k] != victim)
            begin
                mark_traffic();
                cpu_read(make_addr(seq[k], 2, 1), cyc);
                check_traffic(0, 0);
            end
        end
        mark_traffic();
        cpu_read(make_addr(victim, 2, 1), cyc);
        check_traffic(1, 0);
    endtask

    task automatic random_traffic();
        logic wr;
        int   tag;
        int   set;
        int   word;
        int   cyc;
        for (int n = 0; n < 200; n++)
        begin
            wr   = (take_bits(1) == 1);
            tag  = 40 + take_bits(3);
            set  = 3 + take_bits(1);
            word = take_bits(4);
            if (wr)
                cpu_write(make_addr(tag, set, word), lc3b_word'(take_bits(16)));
            else
                cpu_read(make_addr(tag, set, word), cyc);
        end
    endtask

    initial
    begin
        lc3b_word a;
        reset       = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        for (int w = 0; w < 32768; w++)
        begin
            a         = lc3b_word'(w << 1);
            shadow[w] = {a[7:0], a[15:8]};
        end
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        cold_read_miss();
        end_test("cold read miss");
        same_line_hit();
        end_test("same line hit");
        write_hit_read();
        end_test("write hit");
        dirty_eviction();
        end_test("dirty eviction");
        plru_order();
        end_test("plru order");
        random_traffic();
        end_test("random traffic");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule : tb_l2_cache

// File: tb.f
+incdir+verilog
verilog/lc3b_types.sv
verilog/l2_cache_types.sv
verilog/l2_array_if.sv
verilog/l2_tag_lookup.sv
verilog/l2_cache_control.sv
verilog/l2_line_store.sv
verilog/l2_cache.sv
testbench/l2_pmem_model.sv
testbench/l2_cache_chk.sv
testbench/tb_l2_cache.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_l2_cache -f tb.f -o sim_l2_cache
	./obj_dir/sim_l2_cache > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
